/* hdl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [6:0]  funct7_t;

	// ****************************************
	// Major opcodes
	// ****************************************
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_JAL    = 7'b1101111;

	// ****************************************
	// Funct fields
	// ****************************************
	localparam funct3_t F3_ADD = 3'b000;
	localparam funct3_t F3_XOR = 3'b100;
	localparam funct3_t F3_OR  = 3'b110;
	localparam funct3_t F3_AND = 3'b111;
	localparam funct3_t F3_BEQ = 3'b000;
	localparam funct3_t F3_BNE = 3'b001;
	localparam funct3_t F3_LW  = 3'b010;
	localparam funct3_t F3_LBU = 3'b100;
	localparam funct3_t F3_SW  = 3'b010;
	localparam funct3_t F3_SB  = 3'b000;

	// SUB shares funct3 with ADD
	localparam funct7_t F7_SUB = 7'b0100000;

	localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

/* hdl/core_ctrl_pkg.sv */
`default_nettype none

package core_ctrl_pkg;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		WB_NONE,
		WB_ALU,
		WB_MEM,
		WB_PC4
	} wb_sel_e;

	typedef enum logic [2:0] {
		MEM_NONE,
		MEM_LW,
		MEM_LBU,
		MEM_SW,
		MEM_SB
	} mem_op_e;

	typedef enum logic [1:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_JAL
	} br_op_e;

	typedef enum logic [2:0] {
		S_FETCH,
		S_WAIT_INST,
		S_EXEC,
		S_MEM,
		S_WB
	} seq_state_e;

	// Data port command codes
	typedef logic [2:0] d_cmd_t;

	localparam d_cmd_t D_CMD_IDLE  = 3'd0;
	localparam d_cmd_t D_CMD_READ  = 3'd1;
	localparam d_cmd_t D_CMD_WRITE = 3'd2;

endpackage

`default_nettype wire

/* hdl/instr_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_sequencer (
	input  logic              clk,
	input  logic              reset,
	input  logic              inst_ready,
	input  logic              inst_valid,
	input  rv_isa_pkg::inst_t inst,
	input  logic              mem_done,
	input  rv_isa_pkg::word_t next_pc,
	output logic              inst_start,
	output rv_isa_pkg::word_t i_addr,
	output rv_isa_pkg::word_t pc,
	output rv_isa_pkg::inst_t cur_inst,
	output logic              exec_strobe,
	output logic              wb_strobe
);
	import rv_isa_pkg::*;
	import core_ctrl_pkg::*;

	seq_state_e state;
	// Low during reset and the first cycle after it
	logic fetch_enable;

	assign inst_start = (state == S_FETCH) && fetch_enable && inst_ready;
	assign i_addr = pc;
	assign exec_strobe = (state == S_EXEC);
	assign wb_strobe = (state == S_WB);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_FETCH;
			pc <= RESET_PC;
			fetch_enable <= 1'b0;
		end else begin
			fetch_enable <= 1'b1;
			case (state)
				S_FETCH: begin
					if (inst_start) begin
						state <= S_WAIT_INST;
					end
				end
				S_WAIT_INST: begin
					if (inst_valid) begin
						state <= S_EXEC;
					end
				end
				S_EXEC: state <= S_MEM;
				S_MEM: begin
					if (mem_done) begin
						state <= S_WB;
					end
				end
				S_WB: begin
					pc <= next_pc;
					state <= S_FETCH;
				end
				default: state <= S_FETCH;
			endcase
		end
	end

	// Instruction stays put until the next fetch returns
	always_ff @(posedge clk) begin
		if (state == S_WAIT_INST && inst_valid) begin
			cur_inst <= inst;
		end
	end

endmodule

`default_nettype wire

/* hdl/decode_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
	input  rv_isa_pkg::inst_t     cur_inst,
	output rv_isa_pkg::reg_addr_t rs1_addr,
	output rv_isa_pkg::reg_addr_t rs2_addr,
	output rv_isa_pkg::reg_addr_t rd_addr,
	output rv_isa_pkg::word_t     imm,
	output logic                  use_imm,
	output core_ctrl_pkg::alu_op_e alu_op,
	output core_ctrl_pkg::br_op_e  br_op,
	output core_ctrl_pkg::mem_op_e mem_op,
	output core_ctrl_pkg::wb_sel_e wb_sel
);
	import rv_isa_pkg::*;
	import core_ctrl_pkg::*;

	opcode_t opcode;
	funct3_t funct3;
	funct7_t funct7;
	word_t   imm_i;
	word_t   imm_s;
	word_t   imm_b;
	word_t   imm_u;
	word_t   imm_j;

	assign opcode = cur_inst[6:0];
	assign rd_addr = cur_inst[11:7];
	assign funct3 = cur_inst[14:12];
	assign rs1_addr = cur_inst[19:15];
	assign rs2_addr = cur_inst[24:20];
	assign funct7 = cur_inst[31:25];

	// Sign-extended immediates per format
	assign imm_i = {{20{cur_inst[31]}}, cur_inst[31:20]};
	assign imm_s = {{20{cur_inst[31]}}, cur_inst[31:25], cur_inst[11:7]};
	assign imm_b = {{19{cur_inst[31]}}, cur_inst[31], cur_inst[7], cur_inst[30:25],
		cur_inst[11:8], 1'b0};
	assign imm_u = {cur_inst[31:12], 12'd0};
	assign imm_j = {{11{cur_inst[31]}}, cur_inst[31], cur_inst[19:12], cur_inst[20],
		cur_inst[30:21], 1'b0};

	always_comb begin
		imm = imm_i;
		use_imm = 1'b0;
		alu_op = ALU_ADD;
		br_op = BR_NONE;
		mem_op = MEM_NONE;
		wb_sel = WB_NONE;
		case (opcode)
			OPC_OP, OPC_OP_IMM: begin
				use_imm = (opcode == OPC_OP_IMM);
				wb_sel = WB_ALU;
				case (funct3)
					F3_ADD: begin
						alu_op = (opcode == OPC_OP && funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
					end
					F3_XOR: alu_op = ALU_XOR;
					F3_OR: alu_op = ALU_OR;
					F3_AND: alu_op = ALU_AND;
					// Shifts and compares retire as no-ops
					default: wb_sel = WB_NONE;
				endcase
			end
			OPC_LUI: begin
				imm = imm_u;
				use_imm = 1'b1;
				alu_op = ALU_PASS_B;
				wb_sel = WB_ALU;
			end
			OPC_LOAD: begin
				use_imm = 1'b1;
				if (funct3 == F3_LW) begin
					mem_op = MEM_LW;
					wb_sel = WB_MEM;
				end else if (funct3 == F3_LBU) begin
					mem_op = MEM_LBU;
					wb_sel = WB_MEM;
				end
			end
			OPC_STORE: begin
				imm = imm_s;
				use_imm = 1'b1;
				if (funct3 == F3_SW) begin
					mem_op = MEM_SW;
				end else if (funct3 == F3_SB) begin
					mem_op = MEM_SB;
				end
			end
			OPC_BRANCH: begin
				imm = imm_b;
				if (funct3 == F3_BEQ) begin
					br_op = BR_EQ;
				end else if (funct3 == F3_BNE) begin
					br_op = BR_NE;
				end
			end
			OPC_JAL: begin
				imm = imm_j;
				br_op = BR_JAL;
				wb_sel = WB_PC4;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  logic                  clk,
	input  logic                  reset,
	input  rv_isa_pkg::reg_addr_t rs1_addr,
	input  rv_isa_pkg::reg_addr_t rs2_addr,
	input  rv_isa_pkg::reg_addr_t rd_addr,
	input  rv_isa_pkg::word_t     rd_data,
	input  logic                  wr_en,
	output rv_isa_pkg::word_t     rs1_data,
	output rv_isa_pkg::word_t     rs2_data
);
	import rv_isa_pkg::*;

	word_t regs [0:31];

	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

	// x0 is cleared by reset and never written
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && rd_addr != 5'd0) begin
			regs[rd_addr] <= rd_data;
		end
	end

endmodule

`default_nettype wire

/* hdl/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
	input  rv_isa_pkg::word_t      rs1_data,
	input  rv_isa_pkg::word_t      rs2_data,
	input  rv_isa_pkg::word_t      imm,
	input  logic                   use_imm,
	input  core_ctrl_pkg::alu_op_e alu_op,
	output rv_isa_pkg::word_t      alu_out
);
	import rv_isa_pkg::*;
	import core_ctrl_pkg::*;

	word_t op_b;

	assign op_b = use_imm ? imm : rs2_data;

	always_comb begin
		case (alu_op)
			ALU_ADD: alu_out = rs1_data + op_b;
			ALU_SUB: alu_out = rs1_data - op_b;
			ALU_AND: alu_out = rs1_data & op_b;
			ALU_OR: alu_out = rs1_data | op_b;
			ALU_XOR: alu_out = rs1_data ^ op_b;
			// LUI immediate passes straight through
			ALU_PASS_B: alu_out = op_b;
			default: alu_out = rs1_data + op_b;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
	input  rv_isa_pkg::word_t     pc,
	input  rv_isa_pkg::word_t     rs1_data,
	input  rv_isa_pkg::word_t     rs2_data,
	input  rv_isa_pkg::word_t     imm,
	input  core_ctrl_pkg::br_op_e br_op,
	output logic                  br_taken,
	output rv_isa_pkg::word_t     br_target,
	output rv_isa_pkg::word_t     pc_plus4
);
	import core_ctrl_pkg::*;

	logic equal;

	assign equal = (rs1_data == rs2_data);

	always_comb begin
		case (br_op)
			BR_EQ: br_taken = equal;
			BR_NE: br_taken = !equal;
			BR_JAL: br_taken = 1'b1;
			default: br_taken = 1'b0;
		endcase
	end

	// Both branch and JAL targets are pc relative
	assign br_target = pc + imm;
	assign pc_plus4 = pc + 32'd4;

endmodule

`default_nettype wire

/* hdl/memory_access.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_access (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   exec_strobe,
	input  core_ctrl_pkg::mem_op_e mem_op,
	input  core_ctrl_pkg::wb_sel_e wb_sel,
	input  rv_isa_pkg::word_t      alu_out,
	input  rv_isa_pkg::word_t      rs2_data,
	input  rv_isa_pkg::word_t      br_target,
	input  rv_isa_pkg::word_t      pc_plus4,
	input  logic                   br_taken,
	output core_ctrl_pkg::d_cmd_t  d_cmd,
	input  logic                   d_cmd_ready,
	output rv_isa_pkg::word_t      d_addr,
	output rv_isa_pkg::word_t      wdata,
	output rv_isa_pkg::word_t      wmask,
	input  rv_isa_pkg::word_t      rdata,
	input  logic                   rdata_valid,
	output logic                   mem_done,
	output rv_isa_pkg::word_t      wb_data,
	output rv_isa_pkg::word_t      next_pc,
	output logic                   wb_en
);
	import rv_isa_pkg::*;
	import core_ctrl_pkg::*;

	mem_op_e    mem_op_q;
	logic       rd_wait;
	logic       byte_access;
	logic [7:0] rd_byte;
	word_t      load_data;

	assign byte_access = (mem_op == MEM_SB) || (mem_op == MEM_LBU);
	assign rd_byte = rdata[{d_addr[1:0], 3'b000} +: 8];

	// ****************************************
	// Command sequencing
	// ****************************************
	always_ff @(posedge clk) begin
		if (reset) begin
			d_cmd <= D_CMD_IDLE;
			mem_op_q <= MEM_NONE;
			rd_wait <= 1'b0;
			mem_done <= 1'b0;
		end else begin
			mem_done <= 1'b0;
			if (exec_strobe) begin
				mem_op_q <= mem_op;
				case (mem_op)
					MEM_LW, MEM_LBU: d_cmd <= D_CMD_READ;
					MEM_SW, MEM_SB: d_cmd <= D_CMD_WRITE;
					default: mem_done <= 1'b1;
				endcase
			end else if (d_cmd != D_CMD_IDLE && d_cmd_ready) begin
				d_cmd <= D_CMD_IDLE;
				if (d_cmd == D_CMD_READ) begin
					rd_wait <= 1'b1;
				end else begin
					mem_done <= 1'b1;
				end
			end else if (rd_wait && rdata_valid) begin
				rd_wait <= 1'b0;
				mem_done <= 1'b1;
			end
		end
	end

	// Request payload, held until the command is accepted
	always_ff @(posedge clk) begin
		if (exec_strobe) begin
			wdata <= (mem_op == MEM_SB) ? {4{rs2_data[7:0]}} : rs2_data;
			if (byte_access) begin
				d_addr <= alu_out;
				wmask <= 32'h0000_00ff << {alu_out[1:0], 3'b000};
			end else begin
				d_addr <= {alu_out[31:2], 2'b00};
				wmask <= 32'hffff_ffff;
			end
		end
		if (rd_wait && rdata_valid) begin
			load_data <= (mem_op_q == MEM_LBU) ? {24'd0, rd_byte} : rdata;
		end
	end

	// ****************************************
	// Write-back and next PC
	// ****************************************
	always_comb begin
		case (wb_sel)
			WB_MEM: wb_data = load_data;
			WB_PC4: wb_data = pc_plus4;
			WB_ALU: wb_data = alu_out;
			default: wb_data = alu_out;
		endcase
	end

	assign next_pc = br_taken ? br_target : pc_plus4;
	assign wb_en = (wb_sel != WB_NONE);

endmodule

`default_nettype wire

/* hdl/core.sv */
`timescale 1ns/1ps
`default_nettype none

module core (
	input  logic                  clk,
	input  logic                  reset,
	output logic                  inst_start,
	input  logic                  inst_ready,
	output rv_isa_pkg::word_t     i_addr,
	input  rv_isa_pkg::inst_t     inst,
	input  logic                  inst_valid,
	output core_ctrl_pkg::d_cmd_t d_cmd,
	input  logic                  d_cmd_ready,
	output rv_isa_pkg::word_t     d_addr,
	output rv_isa_pkg::word_t     wdata,
	output rv_isa_pkg::word_t     wmask,
	input  rv_isa_pkg::word_t     rdata,
	input  logic                  rdata_valid
);
	import rv_isa_pkg::*;
	import core_ctrl_pkg::*;

	word_t     pc;
	word_t     next_pc;
	inst_t     cur_inst;
	logic      exec_strobe;
	logic      wb_strobe;
	logic      mem_done;
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	reg_addr_t rd_addr;
	word_t     imm;
	logic      use_imm;
	alu_op_e   alu_op;
	br_op_e    br_op;
	mem_op_e   mem_op;
	wb_sel_e   wb_sel;
	word_t     rs1_data;
	word_t     rs2_data;
	word_t     alu_out;
	logic      br_taken;
	word_t     br_target;
	word_t     pc_plus4;
	word_t     wb_data;
	logic      wb_en;
	logic      rf_wr_en;

	assign rf_wr_en = wb_strobe & wb_en;

	// ****************************************
	// Fetch and decode
	// ****************************************
	instr_sequencer sequencer (
		.clk(clk),
		.reset(reset),
		.inst_ready(inst_ready),
		.inst_valid(inst_valid),
		.inst(inst),
		.mem_done(mem_done),
		.next_pc(next_pc),
		.inst_start(inst_start),
		.i_addr(i_addr),
		.pc(pc),
		.cur_inst(cur_inst),
		.exec_strobe(exec_strobe),
		.wb_strobe(wb_strobe)
	);

	decode_unit decoder (
		.cur_inst(cur_inst),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.rd_addr(rd_addr),
		.imm(imm),
		.use_imm(use_imm),
		.alu_op(alu_op),
		.br_op(br_op),
		.mem_op(mem_op),
		.wb_sel(wb_sel)
	);

	register_file regfile (
		.clk(clk),
		.reset(reset),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.rd_addr(rd_addr),
		.rd_data(wb_data),
		.wr_en(rf_wr_en),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data)
	);

	// ****************************************
	// Execute, memory and write-back
	// ****************************************
	alu_unit alu (
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.imm(imm),
		.use_imm(use_imm),
		.alu_op(alu_op),
		.alu_out(alu_out)
	);

	branch_unit branch (
		.pc(pc),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.imm(imm),
		.br_op(br_op),
		.br_taken(br_taken),
		.br_target(br_target),
		.pc_plus4(pc_plus4)
	);

	memory_access memstage (
		.clk(clk),
		.reset(reset),
		.exec_strobe(exec_strobe),
		.mem_op(mem_op),
		.wb_sel(wb_sel),
		.alu_out(alu_out),
		.rs2_data(rs2_data),
		.br_target(br_target),
		.pc_plus4(pc_plus4),
		.br_taken(br_taken),
		.d_cmd(d_cmd),
		.d_cmd_ready(d_cmd_ready),
		.d_addr(d_addr),
		.wdata(wdata),
		.wmask(wmask),
		.rdata(rdata),
		.rdata_valid(rdata_valid),
		.mem_done(mem_done),
		.wb_data(wb_data),
		.next_pc(next_pc),
		.wb_en(wb_en)
	);

endmodule

`default_nettype wire

/* verif/mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_model #(
	parameter logic [31:0] DATA_WORD = 32'h0
) (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        inst_start,
	output logic             inst_ready,
	input  wire logic [31:0] i_addr,
	output logic [31:0]      inst,
	output logic             inst_valid,
	input  wire logic [2:0]  d_cmd,
	output logic             d_cmd_ready,
	input  wire logic [31:0] d_addr,
	input  wire logic [31:0] wdata,
	input  wire logic [31:0] wmask,
	output logic [31:0]      rdata,
	output logic             rdata_valid
);
	localparam logic [6:0] OP = 7'b0110011;
	localparam logic [6:0] OP_IMM = 7'b0010011;
	localparam logic [6:0] LUI = 7'b0110111;
	localparam logic [6:0] LOAD = 7'b0000011;

	logic [31:0] mem [0:255];
	logic [31:0] log_addr [0:63];
	logic [31:0] log_data [0:63];
	logic [31:0] log_mask [0:63];
	int          log_count;
	logic        marker_seen;
	integer      seed;
	int          i_cnt;
	int          d_cnt;
	logic [31:0] i_word;
	logic [31:0] d_word;

	// Acceptances sampled at the rising edge
	logic        acc_i;
	logic [31:0] acc_i_addr;
	logic        acc_d;
	logic [2:0]  acc_cmd;
	logic [31:0] acc_addr;
	logic [31:0] acc_wdata;
	logic [31:0] acc_wmask;

	// ****************************************
	// Instruction encoders
	// ****************************************
	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OP};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [2:0] f3);
		return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	initial begin
		seed = 98646;
		inst_ready = 1'b0;
		inst = 32'h0;
		inst_valid = 1'b0;
		d_cmd_ready = 1'b0;
		rdata = 32'h0;
		rdata_valid = 1'b0;
		log_count = 0;
		marker_seen = 1'b0;
		i_cnt = 0;
		d_cnt = 0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = 32'h5A00_0000 | i;
		end
		mem[128] = DATA_WORD;
		// ALU section, results stored from 0x300
		mem[0] = i_type(12'h123, 5'd0, 3'b000, 5'd1, OP_IMM);
		mem[1] = {20'hF0F0F, 5'd2, LUI};
		mem[2] = i_type(12'h5A5, 5'd2, 3'b000, 5'd2, OP_IMM);
		mem[3] = r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
		mem[4] = s_type(12'h300, 5'd3, 3'b010);
		mem[5] = r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4);
		mem[6] = s_type(12'h304, 5'd4, 3'b010);
		mem[7] = r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5);
		mem[8] = s_type(12'h308, 5'd5, 3'b010);
		mem[9] = r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6);
		mem[10] = s_type(12'h30C, 5'd6, 3'b010);
		mem[11] = r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd7);
		mem[12] = s_type(12'h310, 5'd7, 3'b010);
		mem[13] = i_type(12'h0FF, 5'd2, 3'b111, 5'd8, OP_IMM);
		mem[14] = s_type(12'h314, 5'd8, 3'b010);
		mem[15] = i_type(12'hF00, 5'd1, 3'b110, 5'd9, OP_IMM);
		mem[16] = s_type(12'h318, 5'd9, 3'b010);
		mem[17] = i_type(12'hFFF, 5'd2, 3'b100, 5'd10, OP_IMM);
		mem[18] = s_type(12'h31C, 5'd10, 3'b010);
		mem[19] = {20'hABCDE, 5'd11, LUI};
		mem[20] = s_type(12'h320, 5'd11, 3'b010);
		// Loads from the data word
		mem[21] = i_type(12'h200, 5'd0, 3'b010, 5'd12, LOAD);
		mem[22] = s_type(12'h324, 5'd12, 3'b010);
		mem[23] = i_type(12'h200, 5'd0, 3'b100, 5'd13, LOAD);
		mem[24] = s_type(12'h328, 5'd13, 3'b010);
		mem[25] = i_type(12'h201, 5'd0, 3'b100, 5'd14, LOAD);
		mem[26] = s_type(12'h32C, 5'd14, 3'b010);
		mem[27] = i_type(12'h202, 5'd0, 3'b100, 5'd15, LOAD);
		mem[28] = s_type(12'h330, 5'd15, 3'b010);
		mem[29] = i_type(12'h203, 5'd0, 3'b100, 5'd16, LOAD);
		mem[30] = s_type(12'h334, 5'd16, 3'b010);
		mem[31] = s_type(12'h341, 5'd2, 3'b000);
		// Branches, the skipped stores must not show up
		mem[32] = b_type(13'd8, 5'd1, 5'd1, 3'b000);
		mem[33] = s_type(12'h350, 5'd1, 3'b010);
		mem[34] = b_type(13'd8, 5'd2, 5'd1, 3'b001);
		mem[35] = s_type(12'h354, 5'd1, 3'b010);
		mem[36] = b_type(13'd8, 5'd2, 5'd1, 3'b000);
		mem[37] = s_type(12'h358, 5'd1, 3'b010);
		mem[38] = b_type(13'd8, 5'd1, 5'd1, 3'b001);
		mem[39] = s_type(12'h35C, 5'd2, 3'b010);
		mem[40] = j_type(21'd8, 5'd17);
		mem[41] = s_type(12'h360, 5'd1, 3'b010);
		mem[42] = s_type(12'h364, 5'd17, 3'b010);
		mem[43] = i_type(12'h055, 5'd0, 3'b000, 5'd0, OP_IMM);
		mem[44] = s_type(12'h368, 5'd0, 3'b010);
		mem[45] = i_type(12'h07E, 5'd0, 3'b000, 5'd18, OP_IMM);
		mem[46] = s_type(12'h3FC, 5'd18, 3'b010);
		// Spin here forever
		mem[47] = j_type(21'd0, 5'd0);
	end

	always @(posedge clk) begin
		acc_i <= !reset && inst_start && inst_ready;
		acc_i_addr <= i_addr;
		acc_d <= !reset && (d_cmd != 3'd0) && d_cmd_ready;
		acc_cmd <= d_cmd;
		acc_addr <= d_addr;
		acc_wdata <= wdata;
		acc_wmask <= wmask;
	end

	// ****************************************
	// Responses, driven on the falling edge
	// ****************************************
	always @(negedge clk) begin
		inst_valid = 1'b0;
		rdata_valid = 1'b0;
		inst_ready = ($unsigned($random(seed)) % 4) != 0;
		d_cmd_ready = ($unsigned($random(seed)) % 3) != 0;
		if (reset) begin
			i_cnt = 0;
			d_cnt = 0;
		end else begin
			if (acc_i) begin
				i_word = mem[acc_i_addr[9:2]];
				i_cnt = 1 + int'($unsigned($random(seed)) % 4);
			end
			if (i_cnt > 0) begin
				i_cnt = i_cnt - 1;
				if (i_cnt == 0) begin
					inst = i_word;
					inst_valid = 1'b1;
				end
			end
			if (acc_d && acc_cmd == 3'd1) begin
				d_word = mem[acc_addr[9:2]];
				d_cnt = 1 + int'($unsigned($random(seed)) % 4);
			end else if (acc_d && acc_cmd == 3'd2) begin
				for (int k = 0; k < 4; k++) begin
					if (acc_wmask[8 * k]) begin
						mem[acc_addr[9:2]][8 * k +: 8] = acc_wdata[8 * k +: 8];
					end
				end
				if (log_count < 64) begin
					log_addr[log_count] = acc_addr;
					log_data[log_count] = acc_wdata;
					log_mask[log_count] = acc_wmask;
					log_count = log_count + 1;
				end
				if (acc_addr == 32'h3FC) begin
					marker_seen = 1'b1;
				end
			end
			if (d_cnt > 0) begin
				d_cnt = d_cnt - 1;
				if (d_cnt == 0) begin
					rdata = d_word;
					rdata_valid = 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verif/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb;
	localparam logic [31:0] DATA_WORD = 32'h8765_43A9;
	// Operands built by the program
	localparam logic [31:0] OPND_A = 32'h0000_0123;
	localparam logic [31:0] OPND_B = (32'hF0F0F << 12) + 32'h5A5;
	localparam logic [31:0] FULL = 32'hFFFF_FFFF;

	logic        clk;
	logic        reset;
	wire logic        inst_start;
	wire logic        inst_ready;
	wire logic [31:0] i_addr;
	wire logic [31:0] inst;
	wire logic        inst_valid;
	wire logic [2:0]  d_cmd;
	wire logic        d_cmd_ready;
	wire logic [31:0] d_addr;
	wire logic [31:0] wdata;
	wire logic [31:0] wmask;
	wire logic [31:0] rdata;
	wire logic        rdata_valid;

	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] exp_mask [$];
	logic [2:0]  held_cmd;
	logic [31:0] held_addr;
	logic [31:0] held_wdata;
	logic [31:0] held_wmask;
	logic [2:0]  cur_cmd;
	logic [31:0] cur_addr;
	logic [31:0] cur_wdata;
	logic [31:0] cur_wmask;
	int          cycles;

	core dut0 (
		.clk(clk),
		.reset(reset),
		.inst_start(inst_start),
		.inst_ready(inst_ready),
		.i_addr(i_addr),
		.inst(inst),
		.inst_valid(inst_valid),
		.d_cmd(d_cmd),
		.d_cmd_ready(d_cmd_ready),
		.d_addr(d_addr),
		.wdata(wdata),
		.wmask(wmask),
		.rdata(rdata),
		.rdata_valid(rdata_valid)
	);

	mem_model #(.DATA_WORD(DATA_WORD)) mem0 (
		.clk(clk),
		.reset(reset),
		.inst_start(inst_start),
		.inst_ready(inst_ready),
		.i_addr(i_addr),
		.inst(inst),
		.inst_valid(inst_valid),
		.d_cmd(d_cmd),
		.d_cmd_ready(d_cmd_ready),
		.d_addr(d_addr),
		.wdata(wdata),
		.wmask(wmask),
		.rdata(rdata),
		.rdata_valid(rdata_valid)
	);

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic expect_store(input logic [31:0] a, input logic [31:0] d,
		input logic [31:0] m);
		exp_addr.push_back(a);
		exp_data.push_back(d);
		exp_mask.push_back(m);
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Data port history sampled mid-cycle
	always @(negedge clk) begin
		held_cmd <= cur_cmd;
		held_addr <= cur_addr;
		held_wdata <= cur_wdata;
		held_wmask <= cur_wmask;
		cur_cmd <= d_cmd;
		cur_addr <= d_addr;
		cur_wdata <= wdata;
		cur_wmask <= wmask;
	end

	// ****************************************
	// Handshake checks
	// ****************************************
	assert property (@(posedge clk) disable iff (reset) inst_start |-> inst_ready)
		else stop_with_error("inst_start was raised while inst_ready was low");

	assert property (@(posedge clk) disable iff (reset)
		(d_cmd != 3'd0 && !d_cmd_ready) |=> $stable(d_cmd))
		else stop_with_error($sformatf("mismatch d_cmd: held %h now %h", held_cmd, cur_cmd));

	assert property (@(posedge clk) disable iff (reset)
		(d_cmd != 3'd0 && !d_cmd_ready) |=> $stable(d_addr))
		else stop_with_error($sformatf("mismatch d_addr: held %h now %h", held_addr,
			cur_addr));

	assert property (@(posedge clk) disable iff (reset)
		(d_cmd != 3'd0 && !d_cmd_ready) |=> $stable(wdata))
		else stop_with_error($sformatf("mismatch wdata: held %h now %h", held_wdata,
			cur_wdata));

	assert property (@(posedge clk) disable iff (reset)
		(d_cmd != 3'd0 && !d_cmd_ready) |=> $stable(wmask))
		else stop_with_error($sformatf("mismatch wmask: held %h now %h", held_wmask,
			cur_wmask));

	initial begin
		reset = 1'b1;
		// Stores in program order
		expect_store(32'h300, OPND_A + OPND_B, FULL);
		expect_store(32'h304, OPND_A - OPND_B, FULL);
		expect_store(32'h308, OPND_A & OPND_B, FULL);
		expect_store(32'h30C, OPND_A | OPND_B, FULL);
		expect_store(32'h310, OPND_A ^ OPND_B, FULL);
		expect_store(32'h314, OPND_B & 32'h0FF, FULL);
		expect_store(32'h318, OPND_A | 32'hFFFF_FF00, FULL);
		expect_store(32'h31C, ~OPND_B, FULL);
		expect_store(32'h320, 32'hABCDE << 12, FULL);
		expect_store(32'h324, DATA_WORD, FULL);
		for (int k = 0; k < 4; k++) begin
			expect_store(32'h328 + 4 * k, {24'd0, DATA_WORD[8 * k +: 8]}, FULL);
		end
		expect_store(32'h341, {4{OPND_B[7:0]}}, 32'h0000_00FF << 8);
		expect_store(32'h358, OPND_A, FULL);
		expect_store(32'h35C, OPND_B, FULL);
		// JAL sits at word 40
		expect_store(32'h364, 32'd40 * 4 + 4, FULL);
		expect_store(32'h368, 32'h0, FULL);
		expect_store(32'h3FC, 32'h7E, FULL);

		repeat (10) @(negedge clk);
		reset = 1'b0;
		if (inst_start !== 1'b0) begin
			stop_with_error($sformatf("mismatch inst_start after reset: expected 0 got %h",
				inst_start));
		end
		if (d_cmd !== 3'd0) begin
			stop_with_error($sformatf("mismatch d_cmd after reset: expected 0 got %h", d_cmd));
		end

		cycles = 0;
		while (!mem0.marker_seen && cycles < 20000) begin
			@(negedge clk);
			cycles++;
		end
		if (!mem0.marker_seen) begin
			stop_with_error("timed out waiting for the marker store to 0x3FC");
		end
		repeat (20) @(negedge clk);

		if (mem0.log_count != exp_addr.size()) begin
			stop_with_error($sformatf("mismatch store count: expected %h got %h",
				exp_addr.size(), mem0.log_count));
		end
		for (int i = 0; i < exp_addr.size(); i++) begin
			if (mem0.log_addr[i] !== exp_addr[i]) begin
				stop_with_error($sformatf("mismatch d_addr of store %0d: expected %h got %h",
					i, exp_addr[i], mem0.log_addr[i]));
			end
			if (mem0.log_data[i] !== exp_data[i]) begin
				stop_with_error($sformatf("mismatch wdata of store %0d: expected %h got %h",
					i, exp_data[i], mem0.log_data[i]));
			end
			if (mem0.log_mask[i] !== exp_mask[i]) begin
				stop_with_error($sformatf("mismatch wmask of store %0d: expected %h got %h",
					i, exp_mask[i], mem0.log_mask[i]));
			end
		end
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
hdl/rv_isa_pkg.sv
hdl/core_ctrl_pkg.sv
hdl/instr_sequencer.sv
hdl/decode_unit.sv
hdl/register_file.sv
hdl/alu_unit.sv
hdl/branch_unit.sv
hdl/memory_access.sv
hdl/core.sv
verif/mem_model.sv
verif/core_tb.sv

/* run_sim.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module core_tb \
	-f project.f -o core_tb_sim; then
	echo "Build failed"
	exit 1
fi

output=$(./obj_dir/core_tb_sim 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
	exit 1
fi
if echo "$output" | grep -q "Verification passed"; then
	exit 0
fi
exit 1
